/* build.f */
src/abr_ctrl_pkg.sv
src/abr_host_regs.sv
src/abr_seq_rom.sv
src/abr_prog_seq.sv
src/abr_func_dispatch.sv
src/abr_msg_feeder.sv
src/abr_state_capture.sv
src/abr_ctrl_top.sv
test/abr_clk_gen.sv
test/abr_ctrl_tb.sv

/* src/abr_ctrl_pkg.sv */
/*
 * Keygen controller package
 * Sizes, command and mode encodings, instruction format and shared structs
 */
package abr_ctrl_pkg;

  localparam int DATA_WIDTH      = 32;
  localparam int SEED_NUM_DWORDS = 8;
  localparam int SEED_W          = SEED_NUM_DWORDS * DATA_WIDTH;
  localparam int MSG_WIDTH       = 64;
  localparam int MSG_STRB_W      = 8;
  localparam int MSG_BYTE_IDX_W  = $clog2(MSG_STRB_W);
  localparam int STATE_W         = 1024;
  localparam int PROG_ADDR_W     = 4;
  localparam int OPR_WIDTH       = 8;
  localparam int MSG_CNT_W       = OPR_WIDTH - MSG_BYTE_IDX_W;
  localparam int MEM_ADDR_WIDTH  = 8;
  localparam int HOST_ADDR_W     = 4;

  // Host address map, seed dwords sit at 0 to 7
  localparam logic [HOST_ADDR_W-1:0] CMD_ADDR     = 4'd8;
  localparam logic [HOST_ADDR_W-1:0] ZEROIZE_ADDR = 4'd9;

  typedef enum logic [2:0] {
    ABR_CMD_NONE, ABR_CMD_KEYGEN, ABR_CMD_SIGN, ABR_CMD_VERIFY, ABR_CMD_KEYGEN_SIGN
  } abr_cmd_e;

  typedef enum logic [2:0] {ABR_SAMPLER_NONE, ABR_SHAKE256, ABR_REJ_SAMPLER} abr_sampler_mode_e;
  typedef enum logic [1:0] {ABR_NTT_NONE, ABR_NTT} abr_ntt_mode_e;
  typedef enum logic [3:0] {ABR_SRC_SEED = 4'h1, ABR_SRC_RHO = 4'h2} abr_src_e;
  typedef enum logic [3:0] {ABR_DEST_NONE = 4'h0, ABR_DEST_K_RHO = 4'h1} abr_dest_e;

  typedef struct packed {
    logic              keccak_en;
    logic              sampler_en;
    logic              ntt_en;
    abr_sampler_mode_e sampler_mode;
    abr_ntt_mode_e     ntt_mode;
  } abr_opcode_t;

  typedef struct packed {
    abr_opcode_t          opcode;
    logic [OPR_WIDTH-1:0] operand1;
    logic [OPR_WIDTH-1:0] operand2;
    logic [OPR_WIDTH-1:0] operand3;
    logic [OPR_WIDTH-1:0] length;
    logic [15:0]          iter;
  } abr_instr_t;

  typedef enum logic [PROG_ADDR_W-1:0] {
    ABR_PC_RESET = 4'd0, ABR_PC_KG_S = 4'd1, ABR_PC_KG_E = 4'd5
  } abr_pc_e;

  typedef enum logic [2:0] {
    ABR_DISP_IDLE, ABR_DISP_SHA3_START, ABR_DISP_MSG_START,
    ABR_DISP_MSG_LOAD, ABR_DISP_FUNC_START, ABR_DISP_DONE
  } abr_dispatch_e;

  typedef struct packed {
    logic [MEM_ADDR_WIDTH-1:0] src_base;
    logic [MEM_ADDR_WIDTH-1:0] interim_base;
    logic [MEM_ADDR_WIDTH-1:0] dest_base;
  } abr_ntt_addr_t;

  typedef struct packed {
    logic                   wr;
    logic [HOST_ADDR_W-1:0] addr;
    logic [DATA_WIDTH-1:0]  wdata;
  } abr_host_req_t;

  // K in the top bits, rho in the bottom, matching the sampler state layout
  typedef struct packed {
    logic [255:0] k;
    logic [511:0] rho_p;
    logic [255:0] rho;
  } abr_seed_pack_t;

endpackage

/* src/abr_ctrl_top.sv */
/*
 * Keygen controller top level
 * Host registers, sequencer, dispatcher, message feeder and state capture
 */
`timescale 1ns/10ps

module abr_ctrl_top
  import abr_ctrl_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_b,
  input  abr_host_req_t             host_req_i,
  output abr_sampler_mode_e         sampler_mode_o,
  output logic                      sha3_start_o,
  output logic                      msg_start_o,
  output logic                      msg_valid_o,
  input  logic                      msg_rdy_i,
  output logic [MSG_STRB_W-1:0]     msg_strobe_o,
  output logic [MSG_WIDTH-1:0]      msg_data_o,
  output logic                      sampler_start_o,
  input  logic                      sampler_busy_i,
  input  logic                      sampler_state_dv_i,
  input  logic [STATE_W-1:0]        sampler_state_data_i,
  output logic [MEM_ADDR_WIDTH-1:0] dest_base_addr_o,
  output logic                      ntt_enable_o,
  output abr_ntt_mode_e             ntt_mode_o,
  output abr_ntt_addr_t             ntt_addr_o,
  input  logic                      ntt_busy_i,
  output logic                      ready_o,
  output logic                      valid_o
);

  logic [SEED_NUM_DWORDS-1:0][DATA_WIDTH-1:0] seed;
  abr_cmd_e                                   cmd;
  logic                                       zeroize;
  logic [PROG_ADDR_W-1:0]                     pc_nxt;
  abr_instr_t                                 instr;
  logic                                       disp_busy;
  logic                                       msg_load;
  logic                                       msg_last_xfer;
  logic [SEED_W-1:0]                          rho;

  abr_host_regs host_regs0 (
    .clk        (clk),
    .rst_b      (rst_b),
    .host_req_i (host_req_i),
    .seed_o     (seed),
    .cmd_o      (cmd),
    .zeroize_o  (zeroize)
  );

  abr_prog_seq prog_seq0 (
    .clk            (clk),
    .rst_b          (rst_b),
    .zeroize_i      (zeroize),
    .cmd_i          (cmd),
    .disp_busy_i    (disp_busy),
    .sampler_busy_i (sampler_busy_i),
    .ntt_busy_i     (ntt_busy_i),
    .pc_nxt_o       (pc_nxt),
    .ready_o        (ready_o),
    .valid_o        (valid_o)
  );

  abr_seq_rom seq_rom0 (
    .clk     (clk),
    .rst_b   (rst_b),
    .addr_i  (pc_nxt),
    .instr_o (instr)
  );

  abr_func_dispatch func_dispatch0 (
    .clk             (clk),
    .rst_b           (rst_b),
    .zeroize_i       (zeroize),
    .instr_i         (instr),
    .msg_last_xfer_i (msg_last_xfer),
    .sampler_busy_i  (sampler_busy_i),
    .ntt_busy_i      (ntt_busy_i),
    .sha3_start_o    (sha3_start_o),
    .msg_start_o     (msg_start_o),
    .msg_load_o      (msg_load),
    .sampler_start_o (sampler_start_o),
    .ntt_enable_o    (ntt_enable_o),
    .sampler_mode_o  (sampler_mode_o),
    .ntt_mode_o      (ntt_mode_o),
    .ntt_addr_o      (ntt_addr_o),
    .disp_busy_o     (disp_busy)
  );

  abr_msg_feeder msg_feeder0 (
    .clk             (clk),
    .rst_b           (rst_b),
    .zeroize_i       (zeroize),
    .instr_i         (instr),
    .msg_load_i      (msg_load),
    .msg_rdy_i       (msg_rdy_i),
    .seed_i          (seed),
    .rho_i           (rho),
    .msg_valid_o     (msg_valid_o),
    .msg_strobe_o    (msg_strobe_o),
    .msg_data_o      (msg_data_o),
    .msg_last_xfer_o (msg_last_xfer)
  );

  abr_state_capture state_capture0 (
    .clk              (clk),
    .rst_b            (rst_b),
    .zeroize_i        (zeroize),
    .instr_i          (instr),
    .state_dv_i       (sampler_state_dv_i),
    .state_data_i     (sampler_state_data_i),
    .rho_o            (rho),
    .dest_base_addr_o (dest_base_addr_o)
  );

endmodule

/* src/abr_func_dispatch.sv */
/*
 * Function dispatcher
 * Per-instruction FSM issuing hash, message, sampler and NTT starts
 */
`timescale 1ns/10ps

module abr_func_dispatch
  import abr_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              rst_b,
  input  logic              zeroize_i,
  input  abr_instr_t        instr_i,
  input  logic              msg_last_xfer_i,
  input  logic              sampler_busy_i,
  input  logic              ntt_busy_i,
  output logic              sha3_start_o,
  output logic              msg_start_o,
  output logic              msg_load_o,
  output logic              sampler_start_o,
  output logic              ntt_enable_o,
  output abr_sampler_mode_e sampler_mode_o,
  output abr_ntt_mode_e     ntt_mode_o,
  output abr_ntt_addr_t     ntt_addr_o,
  output logic              disp_busy_o
);

  abr_dispatch_e state_q;
  abr_dispatch_e state_d;

  always_comb begin
    state_d         = state_q;
    sha3_start_o    = 1'b0;
    msg_start_o     = 1'b0;
    msg_load_o      = 1'b0;
    sampler_start_o = 1'b0;
    ntt_enable_o    = 1'b0;
    case (state_q)
      ABR_DISP_IDLE: begin
        if (instr_i.opcode.keccak_en) begin
          state_d = ABR_DISP_SHA3_START;
        end else if (instr_i.opcode.sampler_en || instr_i.opcode.ntt_en) begin
          state_d = ABR_DISP_FUNC_START;
        end
      end
      ABR_DISP_SHA3_START: begin
        sha3_start_o = 1'b1;
        state_d      = ABR_DISP_MSG_START;
      end
      ABR_DISP_MSG_START: begin
        msg_start_o = 1'b1;
        state_d     = ABR_DISP_MSG_LOAD;
      end
      ABR_DISP_MSG_LOAD: begin
        msg_load_o = 1'b1;
        if (msg_last_xfer_i) begin
          state_d = instr_i.opcode.sampler_en ? ABR_DISP_FUNC_START : ABR_DISP_DONE;
        end
      end
      ABR_DISP_FUNC_START: begin
        sampler_start_o = instr_i.opcode.sampler_en;
        ntt_enable_o    = instr_i.opcode.ntt_en;
        state_d         = ABR_DISP_DONE;
      end
      ABR_DISP_DONE: begin
        if (!sampler_busy_i && !ntt_busy_i) begin
          state_d = ABR_DISP_IDLE;
        end
      end
      default: state_d = ABR_DISP_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q <= ABR_DISP_IDLE;
    end else if (zeroize_i) begin
      state_q <= ABR_DISP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Lets the PC advance in the same cycle the last function goes idle
  assign disp_busy_o = (state_d != ABR_DISP_IDLE);

  assign sampler_mode_o = (instr_i.opcode.keccak_en || instr_i.opcode.sampler_en) ?
                          instr_i.opcode.sampler_mode : ABR_SAMPLER_NONE;
  assign ntt_mode_o     = instr_i.opcode.ntt_en ? instr_i.opcode.ntt_mode : ABR_NTT_NONE;
  assign ntt_addr_o     = '{src_base:     instr_i.operand1[MEM_ADDR_WIDTH-1:0],
                            interim_base: instr_i.operand2[MEM_ADDR_WIDTH-1:0],
                            dest_base:    instr_i.operand3[MEM_ADDR_WIDTH-1:0]};

endmodule

/* src/abr_host_regs.sv */
/*
 * Host register port
 * Seed dword storage, one-shot command register and zeroize level
 */
`timescale 1ns/10ps

module abr_host_regs
  import abr_ctrl_pkg::*;
(
  input  logic                                        clk,
  input  logic                                        rst_b,
  input  abr_host_req_t                               host_req_i,
  output logic [SEED_NUM_DWORDS-1:0][DATA_WIDTH-1:0]  seed_o,
  output abr_cmd_e                                    cmd_o,
  output logic                                        zeroize_o
);

  logic [SEED_NUM_DWORDS-1:0][DATA_WIDTH-1:0] seed_q;
  logic [$clog2(SEED_NUM_DWORDS)-1:0]         seed_idx;
  logic                                       seed_wr;
  abr_cmd_e                                   cmd_q;
  logic                                       zeroize_q;

  // Host dword 0 lands in the top slot
  assign seed_idx = $clog2(SEED_NUM_DWORDS)'(SEED_NUM_DWORDS - 1)
                  - host_req_i.addr[$clog2(SEED_NUM_DWORDS)-1:0];
  assign seed_wr  = host_req_i.wr && (host_req_i.addr < HOST_ADDR_W'(SEED_NUM_DWORDS));

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      seed_q <= '0;
    end else if (zeroize_q) begin
      seed_q <= '0;
    end else if (seed_wr) begin
      seed_q[seed_idx] <= host_req_i.wdata;
    end
  end

  // Command is held for a single cycle, then clears
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      cmd_q     <= ABR_CMD_NONE;
      zeroize_q <= 1'b0;
    end else begin
      cmd_q <= ABR_CMD_NONE;
      if (host_req_i.wr && host_req_i.addr == CMD_ADDR && !zeroize_q) begin
        cmd_q <= abr_cmd_e'(host_req_i.wdata[2:0]);
      end
      if (host_req_i.wr && host_req_i.addr == ZEROIZE_ADDR) begin
        zeroize_q <= host_req_i.wdata[0];
      end
    end
  end

  assign seed_o    = seed_q;
  assign cmd_o     = cmd_q;
  assign zeroize_o = zeroize_q;

endmodule

/* src/abr_msg_feeder.sv */
/*
 * Message feeder
 * Counts beats, forms the last-beat strobe and selects seed or rho data
 */
`timescale 1ns/10ps

module abr_msg_feeder
  import abr_ctrl_pkg::*;
(
  input  logic                                       clk,
  input  logic                                       rst_b,
  input  logic                                       zeroize_i,
  input  abr_instr_t                                 instr_i,
  input  logic                                       msg_load_i,
  input  logic                                       msg_rdy_i,
  input  logic [SEED_NUM_DWORDS-1:0][DATA_WIDTH-1:0] seed_i,
  input  logic [SEED_W-1:0]                          rho_i,
  output logic                                       msg_valid_o,
  output logic [MSG_STRB_W-1:0]                      msg_strobe_o,
  output logic [MSG_WIDTH-1:0]                       msg_data_o,
  output logic                                       msg_last_xfer_o
);

  logic [MSG_CNT_W-1:0]  msg_cnt;
  logic                  msg_done;
  logic                  xfer;
  logic [1:0]            beat;
  logic [MSG_STRB_W-1:0] last_strobe;
  abr_src_e              src;

  assign src  = abr_src_e'(instr_i.operand1[3:0]);
  assign beat = msg_cnt[1:0];

  // Whole beats are sent first, then one beat holding the leftover bytes
  assign msg_done    = msg_cnt >= instr_i.length[OPR_WIDTH-1:MSG_BYTE_IDX_W];
  assign last_strobe = ~({MSG_STRB_W{1'b1}} << instr_i.length[MSG_BYTE_IDX_W-1:0]);

  assign xfer            = msg_valid_o && msg_rdy_i;
  assign msg_valid_o     = msg_load_i;
  assign msg_last_xfer_o = xfer && msg_done;
  assign msg_strobe_o    = msg_done ? last_strobe : '1;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      msg_cnt <= '0;
    end else if (zeroize_i || msg_last_xfer_o) begin
      msg_cnt <= '0;
    end else if (xfer) begin
      msg_cnt <= msg_cnt + 1'b1;
    end
  end

  always_comb begin
    msg_data_o = '0;
    if (msg_done) begin
      // Rho gets the iteration count in the final beat
      if (src == ABR_SRC_RHO) begin
        msg_data_o = {{(MSG_WIDTH-16){1'b0}}, instr_i.iter};
      end
    end else begin
      case (src)
        ABR_SRC_SEED: msg_data_o = {seed_i[{beat, 1'b1}], seed_i[{beat, 1'b0}]};
        ABR_SRC_RHO:  msg_data_o = rho_i[beat*MSG_WIDTH +: MSG_WIDTH];
        default:      msg_data_o = '0;
      endcase
    end
  end

endmodule

/* src/abr_prog_seq.sv */
/*
 * Program sequencer
 * Decodes the host command, steps the PC and reports ready and valid
 */
`timescale 1ns/10ps

module abr_prog_seq
  import abr_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic                   zeroize_i,
  input  abr_cmd_e               cmd_i,
  input  logic                   disp_busy_i,
  input  logic                   sampler_busy_i,
  input  logic                   ntt_busy_i,
  output logic [PROG_ADDR_W-1:0] pc_nxt_o,
  output logic                   ready_o,
  output logic                   valid_o
);

  logic [PROG_ADDR_W-1:0] pc_q;
  logic [PROG_ADDR_W-1:0] pc_nxt;
  logic                   keygen_done;
  logic                   valid_q;

  always_comb begin
    pc_nxt      = pc_q;
    keygen_done = 1'b0;
    case (pc_q)
      ABR_PC_RESET: begin
        // Only keygen is implemented, anything else is dropped
        if (cmd_i == ABR_CMD_KEYGEN) begin
          pc_nxt = ABR_PC_KG_S;
        end
      end
      ABR_PC_KG_E: begin
        pc_nxt      = ABR_PC_RESET;
        keygen_done = 1'b1;
      end
      default: begin
        if (!(disp_busy_i || sampler_busy_i || ntt_busy_i)) begin
          pc_nxt = pc_q + 1'b1;
        end
      end
    endcase
    // ROM follows pc_nxt, so park it on the empty reset slot
    if (zeroize_i) begin
      pc_nxt = ABR_PC_RESET;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      pc_q    <= ABR_PC_RESET;
      valid_q <= 1'b0;
    end else if (zeroize_i) begin
      pc_q    <= ABR_PC_RESET;
      valid_q <= 1'b0;
    end else begin
      pc_q <= pc_nxt;
      if (keygen_done) begin
        valid_q <= 1'b1;
      end else if (cmd_i != ABR_CMD_NONE) begin
        valid_q <= 1'b0;
      end
    end
  end

  assign pc_nxt_o = pc_nxt;
  assign ready_o  = (pc_q == ABR_PC_RESET);
  assign valid_o  = valid_q;

endmodule

/* src/abr_seq_rom.sv */
/*
 * Keygen program ROM
 * One instruction per address, output registered
 */
`timescale 1ns/10ps

module abr_seq_rom
  import abr_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic [PROG_ADDR_W-1:0] addr_i,
  output abr_instr_t             instr_o
);

  abr_instr_t instr_q;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      instr_q <= '0;
    end else begin
      case (addr_i)
        // Hash the host seed into rho, rho' and K
        4'd1: instr_q <= '{opcode: '{keccak_en: 1'b1, sampler_en: 1'b1, ntt_en: 1'b0,
                                     sampler_mode: ABR_SHAKE256, ntt_mode: ABR_NTT_NONE},
                           operand1: OPR_WIDTH'(ABR_SRC_SEED),
                           operand2: '0,
                           operand3: OPR_WIDTH'(ABR_DEST_K_RHO),
                           length: 8'd32,
                           iter: 16'd0};
        // Expand rho, iteration counter appended
        4'd2: instr_q <= '{opcode: '{keccak_en: 1'b1, sampler_en: 1'b1, ntt_en: 1'b0,
                                     sampler_mode: ABR_REJ_SAMPLER, ntt_mode: ABR_NTT_NONE},
                           operand1: OPR_WIDTH'(ABR_SRC_RHO),
                           operand2: '0,
                           operand3: OPR_WIDTH'(ABR_DEST_NONE),
                           length: 8'd34,
                           iter: 16'd0};
        4'd3: instr_q <= '{opcode: '{keccak_en: 1'b0, sampler_en: 1'b0, ntt_en: 1'b1,
                                     sampler_mode: ABR_SAMPLER_NONE, ntt_mode: ABR_NTT},
                           operand1: 8'h10,
                           operand2: 8'h20,
                           operand3: 8'h30,
                           length: '0,
                           iter: '0};
        // No-op at 4, end of program at 5, nothing elsewhere
        default: instr_q <= '0;
      endcase
    end
  end

  assign instr_o = instr_q;

endmodule

/* src/abr_state_capture.sv */
/*
 * Sampler state capture
 * Loads rho, rho-prime and K from the sampler state when addressed
 */
`timescale 1ns/10ps

module abr_state_capture
  import abr_ctrl_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_b,
  input  logic                      zeroize_i,
  input  abr_instr_t                instr_i,
  input  logic                      state_dv_i,
  input  logic [STATE_W-1:0]        state_data_i,
  output logic [SEED_W-1:0]         rho_o,
  output logic [MEM_ADDR_WIDTH-1:0] dest_base_addr_o
);

  abr_seed_pack_t seeds_q;
  logic           load;

  assign load = state_dv_i && (instr_i.operand3 == OPR_WIDTH'(ABR_DEST_K_RHO));

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      seeds_q <= '0;
    end else if (zeroize_i) begin
      seeds_q <= '0;
    end else if (load) begin
      seeds_q <= state_data_i;
    end
  end

  assign rho_o            = seeds_q.rho;
  assign dest_base_addr_o = instr_i.operand3[MEM_ADDR_WIDTH-1:0];

endmodule

/* test/abr_clk_gen.sv */
/*
 * Testbench clock and reset generator
 */
`timescale 1ns/10ps

module abr_clk_gen #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_b_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_b_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_b_o = 1'b1;
  end

endmodule

/* test/abr_ctrl_tb.sv */
/*
 * Keygen controller testbench
 * Directed tests with sampler and NTT models, back-pressure and zeroize
 */
`timescale 1ns/10ps

module abr_ctrl_tb
  import abr_ctrl_pkg::*;
();

  localparam int DRIVE_DLY   = 1;
  localparam int SAMPLER_LAT = 4;
  localparam int NTT_LAT     = 6;
  // Three keygen runs, each well under RUN_CYCLES even with random back-pressure
  localparam int NUM_RUNS       = 3;
  localparam int RUN_CYCLES     = 200;
  localparam int TIMEOUT_CYCLES = 5 * NUM_RUNS * RUN_CYCLES;
  localparam int SEED_LEN       = 32;
  localparam int RHO_LEN        = 34;
  localparam logic [15:0] RHO_ITER = 16'd0;

  logic                      clk;
  logic                      rst_b;
  abr_host_req_t             host_req;
  abr_sampler_mode_e         sampler_mode;
  logic                      sha3_start;
  logic                      msg_start;
  logic                      msg_valid;
  logic                      msg_rdy;
  logic [MSG_STRB_W-1:0]     msg_strobe;
  logic [MSG_WIDTH-1:0]      msg_data;
  logic                      sampler_start;
  logic                      sampler_busy;
  logic                      sampler_dv;
  logic [STATE_W-1:0]        sampler_data;
  logic [MEM_ADDR_WIDTH-1:0] dest_base_addr;
  logic                      ntt_enable;
  abr_ntt_mode_e             ntt_mode;
  abr_ntt_addr_t             ntt_addr;
  logic                      ntt_busy;
  logic                      ready;
  logic                      valid;

  logic [31:0]        rng = 32'h670f;
  logic [31:0]        seed_words [SEED_NUM_DWORDS];
  logic [STATE_W-1:0] last_state = '0;
  logic               bp_en = 1'b0;
  int                 err_cnt = 0;
  int                 pass_cnt = 0;
  int                 fail_cnt = 0;
  int                 stall_cnt = 0;
  int                 cycle_cnt = 0;

  abr_clk_gen clk_gen0 (
    .clk_o   (clk),
    .rst_b_o (rst_b)
  );

  abr_ctrl_top dut0 (
    .clk                  (clk),
    .rst_b                (rst_b),
    .host_req_i           (host_req),
    .sampler_mode_o       (sampler_mode),
    .sha3_start_o         (sha3_start),
    .msg_start_o          (msg_start),
    .msg_valid_o          (msg_valid),
    .msg_rdy_i            (msg_rdy),
    .msg_strobe_o         (msg_strobe),
    .msg_data_o           (msg_data),
    .sampler_start_o      (sampler_start),
    .sampler_busy_i       (sampler_busy),
    .sampler_state_dv_i   (sampler_dv),
    .sampler_state_data_i (sampler_data),
    .dest_base_addr_o     (dest_base_addr),
    .ntt_enable_o         (ntt_enable),
    .ntt_mode_o           (ntt_mode),
    .ntt_addr_o           (ntt_addr),
    .ntt_busy_i           (ntt_busy),
    .ready_o              (ready),
    .valid_o              (valid)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      err_cnt = err_cnt + 1;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt = pass_cnt + 1;
      $display("%s: passed", name);
    end else begin
      fail_cnt = fail_cnt + 1;
      $display("%s: failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  task automatic write_host(input logic [HOST_ADDR_W-1:0] addr,
                            input logic [DATA_WIDTH-1:0] data);
    @(posedge clk);
    #DRIVE_DLY;
    host_req.wr    = 1'b1;
    host_req.addr  = addr;
    host_req.wdata = data;
    @(posedge clk);
    #DRIVE_DLY;
    host_req.wr = 1'b0;
  endtask

  // Waits for one transfer, checking that a stalled beat holds its data
  task automatic take_beat(input string name, output logic [MSG_WIDTH-1:0] data,
                           output logic [MSG_STRB_W-1:0] strb);
    logic                  waited;
    logic                  done;
    logic [MSG_WIDTH-1:0]  hold_data;
    logic [MSG_STRB_W-1:0] hold_strb;
    waited    = 1'b0;
    done      = 1'b0;
    hold_data = '0;
    hold_strb = '0;
    while (!done) begin
      @(negedge clk);
      if (msg_valid) begin
        if (waited) begin
          check({name, " data held"}, hold_data, msg_data);
          check({name, " strobe held"}, hold_strb, msg_strobe);
        end
        if (msg_rdy) begin
          done = 1'b1;
        end else begin
          waited    = 1'b1;
          hold_data = msg_data;
          hold_strb = msg_strobe;
          stall_cnt = stall_cnt + 1;
        end
      end
    end
    data = msg_data;
    strb = msg_strobe;
  endtask

  task automatic wait_msg_start(input string name);
    int   sha3_cyc;
    logic early;
    early = 1'b0;
    @(negedge clk);
    while (!sha3_start) begin
      early = early | msg_start;
      @(negedge clk);
    end
    sha3_cyc = cycle_cnt;
    while (!msg_start) @(negedge clk);
    check({name, " msg_start before sha3_start"}, 0, early);
    check({name, " sha3_start precedes msg_start"}, 1, cycle_cnt > sha3_cyc);
  endtask

  // Whole beats first, then one beat with the leftover bytes strobed
  task automatic check_msg(input string name, input logic is_rho);
    logic [MSG_WIDTH-1:0]  data;
    logic [MSG_STRB_W-1:0] strb;
    logic [MSG_WIDTH-1:0]  exp_data;
    logic [255:0]          exp_rho;
    int                    len;
    int                    b;
    len     = is_rho ? RHO_LEN : SEED_LEN;
    exp_rho = last_state[255:0];
    for (b = 0; b < len / 8; b++) begin
      take_beat(name, data, strb);
      if (is_rho) begin
        exp_data = exp_rho[64*b +: 64];
      end else begin
        // Host dword 0 sits in the top slot, beats pair slots from the bottom
        exp_data = {seed_words[6 - 2*b], seed_words[7 - 2*b]};
      end
      check({name, " beat data"}, exp_data, data);
      check({name, " beat strobe"}, 8'hff, strb);
    end
    take_beat(name, data, strb);
    check({name, " last strobe"}, (1 << (len % 8)) - 1, strb);
    if (is_rho) begin
      check({name, " last data"}, {48'd0, RHO_ITER}, data);
    end
  endtask

  task automatic wait_sampler_start(input string name, input abr_sampler_mode_e exp_mode);
    @(negedge clk);
    while (!sampler_start) @(negedge clk);
    check({name, " sampler mode"}, exp_mode, sampler_mode);
  endtask

  task automatic wait_done(input string name, output logic busy_seen);
    busy_seen = 1'b0;
    @(negedge clk);
    while (!valid) begin
      busy_seen = busy_seen | ntt_busy;
      @(negedge clk);
    end
    check({name, " ntt idle at valid"}, 0, ntt_busy);
    check({name, " ready with valid"}, 1, ready);
  endtask

  task automatic test_reset();
    int errs;
    errs = err_cnt;
    @(negedge clk);
    check("reset ready_o", 1, ready);
    check("reset valid_o", 0, valid);
    check("reset msg_valid_o", 0, msg_valid);
    check("reset starts", 0, {sha3_start, msg_start, sampler_start, ntt_enable});
    report_test("reset state", errs);
  endtask

  task automatic test_seed_keygen();
    int errs;
    int i;
    errs = err_cnt;
    for (i = 0; i < SEED_NUM_DWORDS; i++) begin
      rng           = xorshift32(rng);
      seed_words[i] = rng;
      write_host(HOST_ADDR_W'(i), seed_words[i]);
    end
    write_host(CMD_ADDR, DATA_WIDTH'(ABR_CMD_KEYGEN));
    wait_msg_start("seed keygen");
    check_msg("seed keygen", 1'b0);
    wait_sampler_start("seed keygen", ABR_SHAKE256);
    report_test("seed keygen", errs);
  endtask

  task automatic test_rho_feed();
    int errs;
    errs = err_cnt;
    wait_msg_start("rho feed");
    check_msg("rho feed", 1'b1);
    wait_sampler_start("rho feed", ABR_REJ_SAMPLER);
    report_test("rho feed", errs);
  endtask

  task automatic test_ntt_done();
    int   errs;
    logic busy_seen;
    errs = err_cnt;
    @(negedge clk);
    while (!ntt_enable) @(negedge clk);
    check("ntt mode", ABR_NTT, ntt_mode);
    check("ntt src base", 8'h10, ntt_addr.src_base);
    check("ntt interim base", 8'h20, ntt_addr.interim_base);
    check("ntt dest base", 8'h30, ntt_addr.dest_base);
    check("ntt dest_base_addr_o", 8'h30, dest_base_addr);
    wait_done("ntt completion", busy_seen);
    check("ntt busy before valid", 1, busy_seen);
    report_test("ntt and completion", errs);
  endtask

  task automatic test_back_pressure();
    int   errs;
    logic busy_seen;
    errs      = err_cnt;
    bp_en     = 1'b1;
    stall_cnt = 0;
    write_host(CMD_ADDR, DATA_WIDTH'(ABR_CMD_KEYGEN));
    wait_msg_start("back-pressure seed");
    check_msg("back-pressure seed", 1'b0);
    wait_sampler_start("back-pressure seed", ABR_SHAKE256);
    wait_msg_start("back-pressure rho");
    check_msg("back-pressure rho", 1'b1);
    wait_sampler_start("back-pressure rho", ABR_REJ_SAMPLER);
    wait_done("back-pressure", busy_seen);
    bp_en = 1'b0;
    check("back-pressure stalls seen", 1, stall_cnt > 0);
    report_test("back-pressure", errs);
  endtask

  task automatic test_cmd_zeroize();
    int         errs;
    int         i;
    logic [3:0] starts;
    logic       not_ready;
    logic       busy_seen;
    errs      = err_cnt;
    starts    = '0;
    not_ready = 1'b0;
    check("zeroize valid before", 1, valid);
    write_host(ZEROIZE_ADDR, 32'd1);
    // Zeroize register, then one more cycle for the sequencer
    repeat (2) @(negedge clk);
    check("zeroize valid_o", 0, valid);
    check("zeroize msg_valid_o", 0, msg_valid);
    check("zeroize ready_o", 1, ready);
    write_host(ZEROIZE_ADDR, 32'd0);
    write_host(CMD_ADDR, DATA_WIDTH'(ABR_CMD_SIGN));
    repeat (12) begin
      @(negedge clk);
      starts    = starts | {sha3_start, msg_start, sampler_start, ntt_enable};
      not_ready = not_ready | !ready;
    end
    check("sign command starts", 0, starts);
    check("sign command ready dropped", 0, not_ready);
    for (i = 0; i < SEED_NUM_DWORDS; i++) begin
      seed_words[i] = '0;
    end
    write_host(CMD_ADDR, DATA_WIDTH'(ABR_CMD_KEYGEN));
    wait_msg_start("zero seed");
    check_msg("zero seed", 1'b0);
    wait_sampler_start("zero seed", ABR_SHAKE256);
    wait_msg_start("zero seed rho");
    check_msg("zero seed rho", 1'b1);
    wait_done("zero seed", busy_seen);
    report_test("unknown command and zeroize", errs);
  endtask

  // Sampler, NTT and message sink models
  initial begin : responder
    int   smp_cnt;
    int   ntt_cnt;
    int   i;
    logic smp_go;
    logic ntt_go;
    smp_cnt      = 0;
    ntt_cnt      = 0;
    msg_rdy      = 1'b1;
    sampler_busy = 1'b0;
    sampler_dv   = 1'b0;
    sampler_data = '0;
    ntt_busy     = 1'b0;
    forever begin
      @(negedge clk);
      smp_go = sampler_start;
      ntt_go = ntt_enable;
      @(posedge clk);
      #DRIVE_DLY;
      sampler_dv = 1'b0;
      if (smp_go) begin
        smp_cnt      = SAMPLER_LAT;
        sampler_busy = 1'b1;
      end else if (smp_cnt != 0) begin
        smp_cnt = smp_cnt - 1;
        // State is delivered on the last busy cycle
        if (smp_cnt == 1) begin
          for (i = 0; i < STATE_W / 32; i++) begin
            rng                  = xorshift32(rng);
            last_state[32*i +: 32] = rng;
          end
          sampler_data = last_state;
          sampler_dv   = 1'b1;
        end
        if (smp_cnt == 0) begin
          sampler_busy = 1'b0;
        end
      end
      if (ntt_go) begin
        ntt_cnt  = NTT_LAT;
        ntt_busy = 1'b1;
      end else if (ntt_cnt != 0) begin
        ntt_cnt  = ntt_cnt - 1;
        ntt_busy = (ntt_cnt != 0);
      end
      if (bp_en) begin
        rng     = xorshift32(rng);
        msg_rdy = rng[0];
      end else begin
        msg_rdy = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin : main
    host_req = '0;
    wait (rst_b === 1'b1);
    test_reset();
    test_seed_keygen();
    test_rho_feed();
    test_ntt_done();
    test_back_pressure();
    test_cmd_zeroize();
    $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
